//--- bus_protocol_monitor.sv
// bus protocol monitor
`timescale 1ns/10ps
`default_nettype none

module bus_protocol_monitor (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [periph_pkg::fwd_width-1:0] mem_packed_fwd,
    input  logic [periph_pkg::ret_width-1:0] mem_packed_ret,
    output logic                             err_stall,
    output logic                             err_ready_idle,
    output logic                             err_drop,
    output logic                             err_unstable
);

    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic [31:0]           addr;
    logic                  valid;
    logic                  ready;
    logic [67:0]           req;
    logic                  addressed;
    logic                  held;
    logic                  prev_valid;
    logic                  prev_ready;
    logic [67:0]           prev_req;
    logic [31:0]           stall_cnt;
    logic [31:0]           stall_next;

    // ------------------------------------------------------------------------
    // bus view from the cpu side
    // ------------------------------------------------------------------------
    assign wdata = mem_packed_fwd[periph_pkg::wdata_hi:periph_pkg::wdata_lo];
    assign wstrb = mem_packed_fwd[periph_pkg::wstrb_hi:periph_pkg::wstrb_lo];
    assign addr  = mem_packed_fwd[periph_pkg::addr_hi:periph_pkg::addr_lo];
    assign valid = mem_packed_fwd[periph_pkg::valid_bit];
    assign ready = mem_packed_ret[periph_pkg::ready_bit];

    assign req = {addr, wstrb, wdata};

    // unmapped requests may stall forever, so only count mapped ones
    assign addressed =
        (addr[31:14] == {periph_pkg::regfile_base_hi, periph_pkg::regfile_base_lo, 2'b00}) ||
        (addr[31:14] == {periph_pkg::timer_base_hi, periph_pkg::timer_base_lo, 2'b00});

    // a request up and unanswered at the last edge must be kept by the cpu
    assign held = prev_valid && !prev_ready;

    assign stall_next = (valid && !ready && addressed) ? stall_cnt + 32'd1 : 32'h0;

    // ------------------------------------------------------------------------
    // history
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_valid <= 1'b0;
            prev_ready <= 1'b0;
            stall_cnt  <= 32'h0;
        end else begin
            prev_valid <= valid;
            prev_ready <= ready;
            stall_cnt  <= stall_next;
        end
    end

    always_ff @(posedge clk) begin
        prev_req <= req;
    end

    // ------------------------------------------------------------------------
    // sticky error flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            err_stall      <= 1'b0;
            err_ready_idle <= 1'b0;
            err_drop       <= 1'b0;
            err_unstable   <= 1'b0;
        end else begin
            if (stall_next > periph_pkg::max_stall_cycles) begin
                err_stall <= 1'b1;
            end
            if (ready && !valid) begin
                err_ready_idle <= 1'b1;
            end
            // valid fell before any ready
            if (held && !valid) begin
                err_drop <= 1'b1;
            end
            // address, strobes or data moved while waiting
            if (held && valid && req != prev_req) begin
                err_unstable <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bus_return_merge.sv
// sfr return bundle merge
`timescale 1ns/10ps
`default_nettype none

module bus_return_merge (
    input  logic                             clk,
    input  logic [periph_pkg::ret_width-1:0] regfile_ret,
    input  logic [periph_pkg::ret_width-1:0] timer_ret,
    output logic [periph_pkg::ret_width-1:0] mem_packed_ret
);

    logic rf_ready;
    logic tm_ready;

    assign rf_ready = regfile_ret[periph_pkg::ready_bit];
    assign tm_ready = timer_ret[periph_pkg::ready_bit];

    // ------------------------------------------------------------------------
    // combine
    // ------------------------------------------------------------------------
    // an idle block returns all zeros, so a plain or is enough
    // both ready and read data merge the same way
    assign mem_packed_ret = regfile_ret | timer_ret;

    // windows are disjoint, so two answers at once means a decode fault
    a_one_ready: assert property (
        @(posedge clk)
        !(rf_ready && tm_ready)
    );

endmodule

`default_nettype wire

//--- periph_pkg.sv
// peripheral bus definitions
`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------------------
    // packed bus layout
    // ------------------------------------------------------------------------
    // cpu to peripheral bundle
    localparam int fwd_width = 69;
    localparam int wdata_hi  = 68;
    localparam int wdata_lo  = 37;
    localparam int wstrb_hi  = 36;
    localparam int wstrb_lo  = 33;
    localparam int addr_hi   = 32;
    localparam int addr_lo   = 1;
    localparam int valid_bit = 0;

    // peripheral to cpu bundle
    localparam int ret_width = 33;
    localparam int ready_bit = 32;
    localparam int rdata_hi  = 31;
    localparam int rdata_lo  = 0;

    // ------------------------------------------------------------------------
    // address map
    // ------------------------------------------------------------------------
    // a window is selected by addr[31:14] == {base_hi, base_lo, 2'b00}
    localparam logic [7:0] regfile_base_hi = 8'h03;
    localparam logic [7:0] regfile_base_lo = 8'h00;
    localparam logic [7:0] timer_base_hi   = 8'h03;
    localparam logic [7:0] timer_base_lo   = 8'h04;

    // timer word indices, addr[3:2]
    localparam logic [1:0] timer_ctrl_ofs  = 2'd0;
    localparam logic [1:0] timer_count_ofs = 2'd1;
    localparam logic [1:0] timer_cmp_ofs   = 2'd2;
    localparam logic [1:0] timer_stat_ofs  = 2'd3;

    // longest legal run of addressed cycles without ready
    localparam int max_stall_cycles = 3;

    // any strobe bit set makes the request a write
    typedef enum logic {
        acc_read,
        acc_write
    } bus_kind_e;

    // strobed byte merge shared by both sfr blocks
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- periph_tb.sv
// peripheral subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module periph_tb;

    logic                             clk;
    logic                             rst;
    logic [periph_pkg::fwd_width-1:0] fwd;
    logic [periph_pkg::ret_width-1:0] ret;
    logic                             err_stall;
    logic                             err_ready_idle;
    logic                             err_drop;
    logic                             err_unstable;
    logic [3:0]                       flags;
    int                               seed;
    int                               errors;
    int                               timeouts;
    // reference model of the sfr contents
    logic [31:0]                      rf_model [4];
    logic                             tm_enable;
    logic [31:0]                      tm_cmp;
    logic                             tm_match;

    periph_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .mem_packed_fwd (fwd),
        .mem_packed_ret (ret),
        .err_stall      (err_stall),
        .err_ready_idle (err_ready_idle),
        .err_drop       (err_drop),
        .err_unstable   (err_unstable)
    );

    assign flags = {err_stall, err_ready_idle, err_drop, err_unstable};

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // compare tasks and model helpers
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // flag order is stall, ready_idle, drop, unstable
    task automatic check_flags(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // each strobe bit widens to a byte mask over its lane
    function automatic logic [31:0] strobed_word(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic logic [31:0] timer_addr(input logic [1:0] ofs);
        return {periph_pkg::timer_base_hi, periph_pkg::timer_base_lo, 2'b00, 10'h0, ofs, 2'b00};
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        fwd = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 4; i++) begin
            rf_model[i] = 32'h0;
        end
        tm_enable = 1'b0;
        tm_cmp    = 32'h0;
        tm_match  = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // bus side
    // ------------------------------------------------------------------------
    task automatic drive_request(input logic [31:0] addr, input logic [3:0] strb,
                                 input logic [31:0] data);
        fwd[periph_pkg::wdata_hi:periph_pkg::wdata_lo] = data;
        fwd[periph_pkg::wstrb_hi:periph_pkg::wstrb_lo] = strb;
        fwd[periph_pkg::addr_hi:periph_pkg::addr_lo]   = addr;
        fwd[periph_pkg::valid_bit]                     = 1'b1;
    endtask

    // sampled on falling edges
    // read data must stay zero until ready
    task automatic wait_ready(input string name, output logic got, output logic [31:0] data);
        int cycles;
        got    = 1'b0;
        data   = 32'h0;
        cycles = 0;
        while (!got && cycles < 16) begin
            if (ret[periph_pkg::ready_bit]) begin
                got  = 1'b1;
                data = ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo];
            end else begin
                check_word({name, " idle rdata"}, 32'h0,
                           ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo]);
                @(negedge clk);
                cycles++;
            end
        end
        if (!got) begin
            $display("timeout: no ready for %s", name);
            timeouts++;
        end
    endtask

    task automatic bus_access(input string name, input logic [31:0] addr,
                              input logic [3:0] strb, input logic [31:0] data,
                              output logic [31:0] rdata);
        logic got;
        @(negedge clk);
        drive_request(addr, strb, data);
        @(negedge clk);
        wait_ready(name, got, rdata);
        // hold through the commit edge, then release
        @(negedge clk);
        check_word({name, " after ready"}, 32'h0,
                   ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo]);
        fwd = '0;
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] load;
        logic [1:0]  w;
        logic        got;
        int          polls;
        clk      = 1'b0;
        rst      = 1'b1;
        fwd      = '0;
        seed     = 77;
        errors   = 0;
        timeouts = 0;
        apply_reset();

        // random regfile traffic over aliased offsets
        for (int i = 0; i < 200; i++) begin
            rnd  = $random(seed);
            addr = {periph_pkg::regfile_base_hi, periph_pkg::regfile_base_lo, 2'b00, rnd[13:0]};
            rnd  = $random(seed);
            strb = rnd[0] ? 4'h0 : rnd[4:1];
            data = $random(seed);
            w    = addr[3:2];
            bus_access("regfile access", addr, strb, data, rd);
            if (strb == 4'h0) begin
                check_word("regfile read", rf_model[w], rd);
            end else begin
                rf_model[w] = strobed_word(rf_model[w], data, strb);
                check_word("regfile write rdata", 32'h0, rd);
            end
        end
        check_flags("regfile traffic", 4'b0000, flags);

        // stopped counter holds a loaded value
        rnd  = $random(seed);
        load = {4'h0, rnd[27:0]};
        bus_access("timer load", timer_addr(periph_pkg::timer_count_ofs), 4'hf, load, rd);
        bus_access("timer hold", timer_addr(periph_pkg::timer_count_ofs), 4'h0, 32'h0, rd);
        bus_access("timer hold", timer_addr(periph_pkg::timer_count_ofs), 4'h0, 32'h0, rd2);
        check_word("timer hold first", load, rd);
        check_word("timer hold second", load, rd2);
        bus_access("timer enable", timer_addr(periph_pkg::timer_ctrl_ofs), 4'h1, 32'h1, rd);
        tm_enable = 1'b1;
        bus_access("timer disable", timer_addr(periph_pkg::timer_ctrl_ofs), 4'h1, 32'h0, rd);
        tm_enable = 1'b0;
        bus_access("timer ctrl", timer_addr(periph_pkg::timer_ctrl_ofs), 4'h0, 32'h0, rd);
        check_word("timer ctrl", {31'h0, tm_enable}, rd);
        bus_access("timer stop", timer_addr(periph_pkg::timer_count_ofs), 4'h0, 32'h0, rd);
        bus_access("timer stop", timer_addr(periph_pkg::timer_count_ofs), 4'h0, 32'h0, rd2);
        check_word("timer stopped", rd, rd2);
        if (rd < load) begin
            $display("timer count %h fell below the loaded value %h", rd, load);
            errors++;
        end

        // match starts 20 counts short of compare
        rnd    = $random(seed);
        tm_cmp = {8'h0, rnd[23:0]} + 32'd64;
        bus_access("timer cmp", timer_addr(periph_pkg::timer_cmp_ofs), 4'hf, tm_cmp, rd);
        bus_access("timer cmp", timer_addr(periph_pkg::timer_cmp_ofs), 4'h0, 32'h0, rd);
        check_word("timer cmp readback", tm_cmp, rd);
        bus_access("timer preload", timer_addr(periph_pkg::timer_count_ofs), 4'hf,
                   tm_cmp - 32'd20, rd);
        bus_access("timer enable", timer_addr(periph_pkg::timer_ctrl_ofs), 4'h1, 32'h1, rd);
        tm_enable = 1'b1;
        rd    = 32'h0;
        polls = 0;
        while (!rd[0] && polls < 40) begin
            bus_access("timer poll", timer_addr(periph_pkg::timer_stat_ofs), 4'h0, 32'h0, rd);
            polls++;
        end
        if (!rd[0]) begin
            $display("timeout: timer match flag never set");
            timeouts++;
        end
        // count has run past compare by now
        tm_match = 1'b1;
        bus_access("timer disable", timer_addr(periph_pkg::timer_ctrl_ofs), 4'h1, 32'h0, rd);
        tm_enable = 1'b0;
        bus_access("timer clear", timer_addr(periph_pkg::timer_stat_ofs), 4'h1, 32'h1, rd);
        tm_match = 1'b0;
        bus_access("timer status", timer_addr(periph_pkg::timer_stat_ofs), 4'h0, 32'h0, rd);
        check_word("timer status after clear", {31'h0, tm_match}, rd);
        check_flags("legal traffic", 4'b0000, flags);

        // ------------------------------------------------------------------------
        // one protocol fault per reset
        // ------------------------------------------------------------------------
        // write data moves in the wait cycle
        @(negedge clk);
        drive_request({periph_pkg::regfile_base_hi, periph_pkg::regfile_base_lo, 2'b00, 14'h4},
                      4'hf, 32'h1111_1111);
        @(negedge clk);
        fwd[periph_pkg::wdata_hi:periph_pkg::wdata_lo] = 32'h2222_2222;
        wait_ready("unstable fault", got, rd);
        @(negedge clk);
        fwd = '0;
        repeat (2) @(negedge clk);
        check_flags("unstable fault", 4'b0001, flags);
        apply_reset();

        // request withdrawn before the ready edge
        @(negedge clk);
        drive_request({periph_pkg::regfile_base_hi, periph_pkg::regfile_base_lo, 2'b00, 14'h8},
                      4'h0, 32'h0);
        @(negedge clk);
        fwd = '0;
        repeat (3) begin
            @(negedge clk);
            if (ret[periph_pkg::ready_bit]) begin
                $display("withdrawn request still received a ready");
                errors++;
            end
        end
        check_flags("drop fault", 4'b0010, flags);
        apply_reset();

        $display("closing count: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- periph_top.sv
// peripheral subsystem top
`timescale 1ns/10ps
`default_nettype none

module periph_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [periph_pkg::fwd_width-1:0] mem_packed_fwd,
    output logic [periph_pkg::ret_width-1:0] mem_packed_ret,
    output logic                             err_stall,
    output logic                             err_ready_idle,
    output logic                             err_drop,
    output logic                             err_unstable
);

    // per-block return bundles before the merge
    logic [periph_pkg::ret_width-1:0] regfile_ret;
    logic [periph_pkg::ret_width-1:0] timer_ret;

    // ------------------------------------------------------------------------
    // sfr blocks on the shared forward bundle
    // ------------------------------------------------------------------------
    sfr_regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .mem_packed_fwd (mem_packed_fwd),
        .regfile_ret    (regfile_ret)
    );

    sfr_timer u_timer (
        .clk            (clk),
        .rst            (rst),
        .mem_packed_fwd (mem_packed_fwd),
        .timer_ret      (timer_ret)
    );

    // single cpu-facing return
    bus_return_merge u_merge (
        .clk            (clk),
        .regfile_ret    (regfile_ret),
        .timer_ret      (timer_ret),
        .mem_packed_ret (mem_packed_ret)
    );

    // ------------------------------------------------------------------------
    // protocol monitor on the merged bus
    // ------------------------------------------------------------------------
    bus_protocol_monitor u_monitor (
        .clk            (clk),
        .rst            (rst),
        .mem_packed_fwd (mem_packed_fwd),
        .mem_packed_ret (mem_packed_ret),
        .err_stall      (err_stall),
        .err_ready_idle (err_ready_idle),
        .err_drop       (err_drop),
        .err_unstable   (err_unstable)
    );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the peripheral testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module periph_tb -f sim.f -o periph_sim

sim_out=$(./obj_dir/periph_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "Testbench passed"

//--- sfr_regfile.sv
// scratch register file sfr
`timescale 1ns/10ps
`default_nettype none

module sfr_regfile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [periph_pkg::fwd_width-1:0] mem_packed_fwd,
    output logic [periph_pkg::ret_width-1:0] regfile_ret
);

    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic [31:0]           addr;
    logic                  valid;
    logic                  sel;
    logic [1:0]            word;
    periph_pkg::bus_kind_e kind;
    logic                  pending;
    logic                  ready;
    logic [31:0]           rdata;
    logic [31:0]           regs [4];

    // ------------------------------------------------------------------------
    // unpack and decode
    // ------------------------------------------------------------------------
    assign wdata = mem_packed_fwd[periph_pkg::wdata_hi:periph_pkg::wdata_lo];
    assign wstrb = mem_packed_fwd[periph_pkg::wstrb_hi:periph_pkg::wstrb_lo];
    assign addr  = mem_packed_fwd[periph_pkg::addr_hi:periph_pkg::addr_lo];
    assign valid = mem_packed_fwd[periph_pkg::valid_bit];

    // only bits 3..2 decoded inside the window, so it aliases
    assign sel  = valid && (addr[31:14] ==
                  {periph_pkg::regfile_base_hi, periph_pkg::regfile_base_lo, 2'b00});
    assign word = addr[3:2];
    assign kind = (|wstrb) ? periph_pkg::acc_write : periph_pkg::acc_read;

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------
    // arm on the first selected cycle, drop again after one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= sel && !pending;
        end
    end

    // a request withdrawn during the wait cycle gets no answer
    assign ready = pending && sel;

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    // write commits on the ready edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (ready && kind == periph_pkg::acc_write) begin
            regs[word] <= periph_pkg::merge_bytes(regs[word], wdata, wstrb);
        end
    end

    // read data only in the ready cycle of a read
    assign rdata = (ready && kind == periph_pkg::acc_read) ? regs[word] : 32'h0;

    assign regfile_ret[periph_pkg::ready_bit]                     = ready;
    assign regfile_ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo] = rdata;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // ready is a single-cycle pulse
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        ready |=> !ready
    );

    // return bundle stays quiet between answers
    a_rdata_idle: assert property (
        @(posedge clk) disable iff (rst)
        !regfile_ret[periph_pkg::ready_bit] |->
            regfile_ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo] == 32'h0
    );

endmodule

`default_nettype wire

//--- sfr_timer.sv
// timer sfr with compare match
`timescale 1ns/10ps
`default_nettype none

module sfr_timer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [periph_pkg::fwd_width-1:0] mem_packed_fwd,
    output logic [periph_pkg::ret_width-1:0] timer_ret
);

    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic [31:0]           addr;
    logic                  valid;
    logic                  sel;
    logic [1:0]            word;
    periph_pkg::bus_kind_e kind;
    logic                  pending;
    logic                  ready;
    logic                  wr;
    logic                  enable;
    logic [31:0]           count;
    logic [31:0]           cmp;
    logic                  match;
    logic                  match_set;
    logic                  match_clr;
    logic [31:0]           rd_word;
    logic [31:0]           rdata;

    // ------------------------------------------------------------------------
    // unpack and decode
    // ------------------------------------------------------------------------
    assign wdata = mem_packed_fwd[periph_pkg::wdata_hi:periph_pkg::wdata_lo];
    assign wstrb = mem_packed_fwd[periph_pkg::wstrb_hi:periph_pkg::wstrb_lo];
    assign addr  = mem_packed_fwd[periph_pkg::addr_hi:periph_pkg::addr_lo];
    assign valid = mem_packed_fwd[periph_pkg::valid_bit];

    assign sel  = valid && (addr[31:14] ==
                  {periph_pkg::timer_base_hi, periph_pkg::timer_base_lo, 2'b00});
    assign word = addr[3:2];
    assign kind = (|wstrb) ? periph_pkg::acc_write : periph_pkg::acc_read;

    // same one-wait-cycle handshake as the register file
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= sel && !pending;
        end
    end

    assign ready = pending && sel;
    assign wr    = ready && kind == periph_pkg::acc_write;

    // ------------------------------------------------------------------------
    // counter, compare and status
    // ------------------------------------------------------------------------
    // match is checked against the live count every enabled cycle
    assign match_set = enable && (count == cmp);
    // write-one-to-clear on status bit 0
    assign match_clr = wr && word == periph_pkg::timer_stat_ofs && wstrb[0] && wdata[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            count  <= 32'h0;
            cmp    <= 32'h0;
            match  <= 1'b0;
        end else begin
            if (wr && word == periph_pkg::timer_ctrl_ofs && wstrb[0]) begin
                enable <= wdata[0];
            end
            // a bus load overrides the increment
            if (wr && word == periph_pkg::timer_count_ofs) begin
                count <= periph_pkg::merge_bytes(count, wdata, wstrb);
            end else if (enable) begin
                count <= count + 32'd1;
            end
            if (wr && word == periph_pkg::timer_cmp_ofs) begin
                cmp <= periph_pkg::merge_bytes(cmp, wdata, wstrb);
            end
            // set wins over a clear in the same cycle
            match <= match_set || (match && !match_clr);
        end
    end

    // ------------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------------
    always_comb begin
        case (word)
            periph_pkg::timer_ctrl_ofs:  rd_word = {31'h0, enable};
            periph_pkg::timer_count_ofs: rd_word = count;
            periph_pkg::timer_cmp_ofs:   rd_word = cmp;
            periph_pkg::timer_stat_ofs:  rd_word = {31'h0, match};
            default:                     rd_word = 32'h0;
        endcase
    end

    assign rdata = (ready && kind == periph_pkg::acc_read) ? rd_word : 32'h0;

    assign timer_ret[periph_pkg::ready_bit]                     = ready;
    assign timer_ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo] = rdata;

    // ready is a single-cycle pulse
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst)
        ready |=> !ready
    );

    // return bundle stays quiet between answers
    a_rdata_idle: assert property (
        @(posedge clk) disable iff (rst)
        !timer_ret[periph_pkg::ready_bit] |->
            timer_ret[periph_pkg::rdata_hi:periph_pkg::rdata_lo] == 32'h0
    );

endmodule

`default_nettype wire

//--- sim.f
periph_pkg.sv
sfr_regfile.sv
sfr_timer.sv
bus_return_merge.sv
bus_protocol_monitor.sv
periph_top.sv
periph_tb.sv
